/* cache_tq.sv */
// cache transaction queue top level
// sits between the core, the lookup pipe and far memory
`timescale 1ns/1ps

module cache_tq (
    input  logic               clk,
    input  logic               rst_n,
    // core side
    input  tq_pkg::core_req_t  core_req,
    output logic               stall,
    output tq_pkg::core_rsp_t  core_rsp,
    // far memory
    input  tq_pkg::fm_rsp_t    fm_rsp,
    // lookup pipe
    output tq_pkg::lu_req_t    lu_req,
    input  tq_pkg::lu_rsp_t    lu_rsp
);

    tq_pkg::tq_state_e [tq_pkg::NUM_TQ_ENTRY-1:0] state;
    logic [tq_pkg::NUM_TQ_ENTRY-1:0]               alloc;
    logic [tq_pkg::NUM_TQ_ENTRY-1:0]               fill_ready;
    logic [tq_pkg::NUM_TQ_ENTRY-1:0]               rd_hit;
    logic [tq_pkg::NUM_TQ_ENTRY-1:0]               wr_hit;
    tq_pkg::tq_id_t                                alloc_id;
    tq_pkg::tq_id_t                                wr_hit_id;
    tq_pkg::tq_id_t                                fill_id;
    logic                                          any_mb_hit;
    logic                                          fill_grant;
    tq_pkg::fill_entry_t                           fill_entry;

    tq_entry_fsm u_entry_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .core_req   (core_req),
        .any_mb_hit (any_mb_hit),
        .lu_rsp     (lu_rsp),
        .fm_rsp     (fm_rsp),
        .fill_grant (fill_grant),
        .fill_id    (fill_id),
        .state      (state),
        .alloc      (alloc),
        .alloc_id   (alloc_id),
        .fill_ready (fill_ready),
        .stall      (stall)
    );

    tq_merge_buffer u_merge_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .core_req   (core_req),
        .state      (state),
        .alloc      (alloc),
        .fm_rsp     (fm_rsp),
        .fill_id    (fill_id),
        .rd_hit     (rd_hit),
        .wr_hit     (wr_hit),
        .any_mb_hit (any_mb_hit),
        .wr_hit_id  (wr_hit_id),
        .fill_entry (fill_entry)
    );

    tq_fill_arbiter u_fill_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .fill_ready (fill_ready),
        .core_valid (core_req.valid),
        .fill_grant (fill_grant),
        .fill_id    (fill_id)
    );

    tq_pipe_port u_pipe_port (
        .core_req   (core_req),
        .alloc_id   (alloc_id),
        .wr_hit_id  (wr_hit_id),
        .rd_hit     (rd_hit),
        .wr_hit     (wr_hit),
        .fill_grant (fill_grant),
        .fill_id    (fill_id),
        .fill_entry (fill_entry),
        .lu_req     (lu_req),
        .lu_rsp     (lu_rsp),
        .core_rsp   (core_rsp)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# builds the cache TQ testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module tb_cache_tq -Mdir obj_dir

out=$(./obj_dir/Vtb_cache_tq)
echo "$out"

if echo "$out" | grep -qx "No errors"; then
    exit 0
else
    exit 1
fi

/* tb_cache_tq.sv */
// testbench for the cache transaction queue
// models the lookup pipe and far memory, drives core traffic, checks with assertions
`timescale 1ns/1ps

module tb_cache_tq;

    localparam int             MAX_CYCLES = 2000;  // 6 tests of up to 300 cycles
    localparam int             NUM_TESTS  = 6;
    localparam logic [3:0]     FM_DELAY   = 4'd4;

    logic                clk = 1'b0;
    logic                rst_n;
    tq_pkg::core_req_t   core_req;
    logic                stall;
    tq_pkg::core_rsp_t   core_rsp;
    tq_pkg::fm_rsp_t     fm_rsp = '0;
    tq_pkg::lu_req_t     lu_req;
    tq_pkg::lu_rsp_t     lu_rsp = '0;

    int seed = 10;
    int errors = 0;
    int passed = 0;
    int err_start;
    int cycles = 0;

    // pipe and far memory state
    tq_pkg::line_t   pipe_mem [16];
    logic [15:0]     resident;
    tq_pkg::lu_rsp_t st0, rsp_q;
    tq_pkg::fm_rsp_t fm_q;
    logic [3:0]      fm_cnt [4];

    // expected state
    tq_pkg::line_t   golden [16];   // what each line must hold
    logic [3:0]      entry_line [4];
    logic [4:0]      rd_reg [16];
    logic [1:0]      rd_off [16];   // word asked for by the pending read
    logic [15:0]     rd_pending, rd_mark;
    logic [15:0][3:0] wr_mask;
    logic [3:0]      busy, ready_m;
    tq_pkg::tq_id_t  rr_ptr, exp_fill_id, cand;
    logic            found, exp_cancel, saw_stall;
    logic [3:0]      fill_idx, rsp_idx;
    tq_pkg::line_t   exp_fill_line;
    logic            exp_fill_rd, exp_rsp_pending;
    logic [19:0]     exp_rsp_addr;
    logic [31:0]     exp_rsp_data;
    logic [4:0]      exp_rsp_reg;

    cache_tq dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .core_req (core_req),
        .stall    (stall),
        .core_rsp (core_rsp),
        .fm_rsp   (fm_rsp),
        .lu_req   (lu_req),
        .lu_rsp   (lu_rsp)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the queue never drained", cycles);
            $display("Errors found");
            $finish;
        end
    end

    // resident lines start with an address pattern
    function automatic tq_pkg::line_t line_pattern(input logic [3:0] idx);
        tq_pkg::line_t l;
        logic [19:0]   a;
        for (int w = 0; w < 4; w++) begin
            a    = {12'h000, idx, 2'(w), 2'b00};
            l[w] = {12'hc0d, a};
        end
        return l;
    endfunction

    // ----------------------------------------
    // pipe and far memory models
    // ----------------------------------------
    always @(posedge clk) begin : pipe_model
        tq_pkg::lu_rsp_t r;
        logic [3:0]      idx;
        r   = '0;
        idx = lu_req.address[7:4];
        if (!rst_n) begin
            resident <= 16'h000f;
            st0      <= '0;
            rsp_q    <= '0;
            for (int i = 0; i < 16; i++) pipe_mem[i] <= line_pattern(4'(i));
        end else begin
            if (lu_req.valid && !lu_req.mb_hit_cancel) begin  // cancelled ones vanish
                r.valid         = 1'b1;
                r.lu_op         = lu_req.lu_op;
                r.address       = lu_req.address;
                r.tq_id         = lu_req.tq_id;
                r.reg_id        = lu_req.reg_id;
                r.rd_indication = lu_req.rd_indication;
                if (lu_req.lu_op == tq_pkg::FILL_LU) begin
                    r.lu_result   = tq_pkg::FILL;
                    r.line        = lu_req.payload.line;
                    pipe_mem[idx] <= lu_req.payload.line;
                    resident[idx] <= 1'b1;
                end else if (resident[idx]) begin
                    r.lu_result = tq_pkg::HIT;
                    r.line      = pipe_mem[idx];
                end else begin
                    r.lu_result = tq_pkg::MISS;
                end
            end
            st0   <= r;
            rsp_q <= st0;  // second stage
        end
    end

    always @(posedge clk) begin : far_memory
        tq_pkg::fm_rsp_t r;
        logic            sent;
        r    = '0;
        sent = 1'b0;
        if (!rst_n) begin
            fm_q <= '0;
            for (int i = 0; i < 4; i++) fm_cnt[i] <= 4'd0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (fm_cnt[i] == 4'd1 && !sent) begin
                    sent    = 1'b1;
                    r.valid = 1'b1;
                    r.tq_id = tq_pkg::tq_id_t'(i);
                    for (int w = 0; w < 4; w++) r.line[w] = $random(seed);
                    fm_cnt[i] <= 4'd0;
                end else if (fm_cnt[i] > 4'd1) begin
                    fm_cnt[i] <= fm_cnt[i] - 4'd1;
                end
            end
            if (lu_rsp.valid && lu_rsp.lu_result == tq_pkg::MISS)
                fm_cnt[lu_rsp.tq_id] <= FM_DELAY;
            fm_q <= r;
        end
    end

    always @(posedge clk) begin
        #1;
        lu_rsp = rsp_q;
        fm_rsp = fm_q;
    end

    // ----------------------------------------
    // expected values
    // ----------------------------------------
    always @(posedge clk) begin : scoreboard
        tq_pkg::line_t nl;
        logic [3:0]    fi, ci;
        fi = entry_line[fm_rsp.tq_id];
        ci = core_req.address[7:4];
        if (!rst_n) begin
            busy       <= '0;
            ready_m    <= '0;
            rr_ptr     <= '0;
            saw_stall  <= 1'b0;
            rd_pending <= '0;
            rd_mark    <= '0;
            wr_mask    <= '0;
            for (int i = 0; i < 16; i++) golden[i] <= line_pattern(4'(i));
        end else begin
            if (stall) saw_stall <= 1'b1;
            if (lu_req.valid && lu_req.lu_op != tq_pkg::FILL_LU && !lu_req.mb_hit_cancel) begin
                busy[lu_req.tq_id]       <= 1'b1;  // new entry
                entry_line[lu_req.tq_id] <= lu_req.address[7:4];
            end
            if (lu_rsp.valid && lu_rsp.lu_result == tq_pkg::HIT) busy[lu_rsp.tq_id] <= 1'b0;
            if (lu_req.valid && lu_req.lu_op == tq_pkg::FILL_LU) begin
                busy[lu_req.tq_id]    <= 1'b0;
                ready_m[lu_req.tq_id] <= 1'b0;
                rr_ptr                <= exp_fill_id + 2'd1;
                wr_mask[fill_idx]     <= 4'h0;
                rd_mark[fill_idx]     <= 1'b0;
            end
            if (fm_rsp.valid) begin  // written words stay
                ready_m[fm_rsp.tq_id] <= 1'b1;
                for (int w = 0; w < 4; w++) begin
                    nl[w] = wr_mask[fi][w] ? golden[fi][w] : fm_rsp.line[w];
                end
                golden[fi] <= nl;
            end
            if (core_req.valid && core_req.opcode == tq_pkg::WR_OP) begin
                golden[ci][core_req.address[3:2]]  <= core_req.data;
                wr_mask[ci][core_req.address[3:2]] <= 1'b1;
            end else if (core_req.valid) begin
                rd_pending[ci] <= 1'b1;
                rd_reg[ci]     <= core_req.reg_id;
                rd_off[ci]     <= core_req.address[3:2];
                if (!resident[ci]) rd_mark[ci] <= 1'b1;
            end
            if (core_rsp.valid) rd_pending[rsp_idx] <= 1'b0;
        end
    end

    always_comb begin
        // walk from the pointer to the first ready entry
        found       = 1'b0;
        exp_fill_id = rr_ptr;
        cand        = rr_ptr;
        for (int k = 0; k < 4; k++) begin
            cand = rr_ptr + tq_pkg::tq_id_t'(k);
            if (!found && ready_m[cand]) begin
                found       = 1'b1;
                exp_fill_id = cand;
            end
        end
        fill_idx        = entry_line[exp_fill_id];  // line of the entry due next
        exp_fill_line   = golden[fill_idx];
        exp_fill_rd     = rd_mark[fill_idx];
        rsp_idx         = core_rsp.address[7:4];
        exp_rsp_addr    = {12'h000, rsp_idx, rd_off[rsp_idx], 2'b00};
        exp_rsp_data    = golden[rsp_idx][rd_off[rsp_idx]];
        exp_rsp_reg     = rd_reg[rsp_idx];
        exp_rsp_pending = rd_pending[rsp_idx];
    end

    // ----------------------------------------
    // assertions
    // ----------------------------------------
    a_cancel: assert property (@(posedge clk) disable iff (!rst_n)
        core_req.valid |-> (lu_req.mb_hit_cancel == exp_cancel))
        else begin
            $display("ERROR lu_req.mb_hit_cancel: got %h expected %h",
                     $sampled(lu_req.mb_hit_cancel), $sampled(exp_cancel));
            errors++;
        end

    a_fill_slot: assert property (@(posedge clk) disable iff (!rst_n)
        (lu_req.valid && lu_req.lu_op == tq_pkg::FILL_LU) |-> !core_req.valid)
        else begin
            $display("fill lookup issued in a cycle with a core request");
            errors++;
        end

    a_fill_id: assert property (@(posedge clk) disable iff (!rst_n)
        (lu_req.valid && lu_req.lu_op == tq_pkg::FILL_LU) |-> (lu_req.tq_id == exp_fill_id))
        else begin
            $display("ERROR lu_req.tq_id: got %h expected %h",
                     $sampled(lu_req.tq_id), $sampled(exp_fill_id));
            errors++;
        end

    a_fill_line: assert property (@(posedge clk) disable iff (!rst_n)
        (lu_req.valid && lu_req.lu_op == tq_pkg::FILL_LU) |->
        (lu_req.address[19:4] == {12'h000, fill_idx} &&
         lu_req.payload.line == exp_fill_line && lu_req.rd_indication == exp_fill_rd))
        else begin
            $display("ERROR lu_req.address[19:4]: got %h expected %h",
                     $sampled(lu_req.address[19:4]), {12'h000, $sampled(fill_idx)});
            $display("ERROR lu_req.payload.line: got %h expected %h",
                     $sampled(lu_req.payload.line), $sampled(exp_fill_line));
            $display("ERROR lu_req.rd_indication: got %h expected %h",
                     $sampled(lu_req.rd_indication), $sampled(exp_fill_rd));
            errors++;
        end

    a_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        core_rsp.valid |->
        (exp_rsp_pending && core_rsp.address == exp_rsp_addr &&
         core_rsp.data == exp_rsp_data && core_rsp.reg_id == exp_rsp_reg))
        else begin
            $display("ERROR core_rsp.address: got %h expected %h, pending %h",
                     $sampled(core_rsp.address), $sampled(exp_rsp_addr),
                     $sampled(exp_rsp_pending));
            $display("ERROR core_rsp.data: got %h expected %h",
                     $sampled(core_rsp.data), $sampled(exp_rsp_data));
            $display("ERROR core_rsp.reg_id: got %h expected %h",
                     $sampled(core_rsp.reg_id), $sampled(exp_rsp_reg));
            errors++;
        end

    a_stall: assert property (@(posedge clk) disable iff (!rst_n) stall == (&busy))
        else begin
            $display("ERROR stall: got %h expected %h", $sampled(stall), $sampled(&busy));
            errors++;
        end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    task automatic bus_idle();
        @(posedge clk);
        #1;
        core_req = '0;
    endtask

    task automatic issue(input tq_pkg::opcode_e op, input logic [3:0] line_idx,
                         input logic [1:0] off, input logic [4:0] reg_id,
                         input logic [31:0] data, input logic cancel);
        @(posedge clk);
        #1;
        core_req = '0;
        while (stall) begin  // core holds back
            @(posedge clk);
            #1;
        end
        core_req.valid   = 1'b1;
        core_req.opcode  = op;
        core_req.address = {12'h000, line_idx, off, 2'b00};
        core_req.reg_id  = reg_id;
        core_req.data    = data;
        exp_cancel       = cancel;
    endtask

    task automatic wait_done();
        bus_idle();
        while ((|busy) || (|rd_pending)) bus_idle();
    endtask

    task automatic end_test(input int num, input string name);
        if (errors == err_start) begin
            passed++;
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: failed", num, name);
        end
        err_start = errors;
    endtask

    initial begin
        core_req   = '0;
        exp_cancel = 1'b0;
        rst_n      = 1'b0;
        repeat (5) @(posedge clk);
        #1 rst_n = 1'b1;
        err_start = errors;

        assert (!stall && !lu_req.valid && !core_rsp.valid) else begin
            $display("ERROR reset outputs: stall %h lu_req.valid %h core_rsp.valid %h",
                     stall, lu_req.valid, core_rsp.valid);
            errors++;
        end
        end_test(1, "after_reset");

        issue(tq_pkg::RD_OP, 4'd1, 2'd2, 5'd3, 32'h0, 1'b0);
        issue(tq_pkg::RD_OP, 4'd3, 2'd1, 5'd4, 32'h0, 1'b0);
        wait_done();
        end_test(2, "read_hit");

        issue(tq_pkg::RD_OP, 4'd4, 2'd3, 5'd7, 32'h0, 1'b0);
        wait_done();
        end_test(3, "read_miss");

        issue(tq_pkg::WR_OP, 4'd5, 2'd0, 5'd0, $random(seed), 1'b0);
        issue(tq_pkg::WR_OP, 4'd5, 2'd2, 5'd0, $random(seed), 1'b1);
        bus_idle();  // let the miss land first
        issue(tq_pkg::RD_OP, 4'd5, 2'd2, 5'd9, 32'h0, 1'b1);
        wait_done();
        end_test(4, "write_merge");

        for (int i = 0; i < 4; i++)
            issue(tq_pkg::RD_OP, 4'(6 + i), 2'(i), 5'(10 + i), 32'h0, 1'b0);
        issue(tq_pkg::RD_OP, 4'd0, 2'd1, 5'd14, 32'h0, 1'b0);
        wait_done();
        assert (saw_stall) else begin
            $display("stall did not rise with all four entries busy");
            errors++;
        end
        end_test(5, "stall");

        // one lone fill moves the pointer past entry 0
        issue(tq_pkg::WR_OP, 4'd13, 2'd2, 5'd0, $random(seed), 1'b0);
        wait_done();
        issue(tq_pkg::WR_OP, 4'd10, 2'd0, 5'd0, $random(seed), 1'b0);
        issue(tq_pkg::WR_OP, 4'd11, 2'd1, 5'd0, $random(seed), 1'b0);
        issue(tq_pkg::WR_OP, 4'd12, 2'd3, 5'd0, $random(seed), 1'b0);
        repeat (12) issue(tq_pkg::WR_OP, 4'd10, 2'd1, 5'd0, $random(seed), 1'b1);
        wait_done();
        end_test(6, "fill_order");

        bus_idle();
        $display("%0d of %0d tests passed, %0d errors", passed, NUM_TESTS, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* tq_entry_fsm.sv */
// per-entry state machines of the transaction queue
// picks the entry for a new miss and raises stall when none is free
`timescale 1ns/1ps

module tq_entry_fsm (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  tq_pkg::core_req_t                             core_req,
    input  logic                                          any_mb_hit,
    input  tq_pkg::lu_rsp_t                               lu_rsp,
    input  tq_pkg::fm_rsp_t                               fm_rsp,
    input  logic                                          fill_grant,
    input  tq_pkg::tq_id_t                                fill_id,
    output tq_pkg::tq_state_e [tq_pkg::NUM_TQ_ENTRY-1:0] state,
    output logic [tq_pkg::NUM_TQ_ENTRY-1:0]               alloc,
    output tq_pkg::tq_id_t                                alloc_id,
    output logic [tq_pkg::NUM_TQ_ENTRY-1:0]               fill_ready,
    output logic                                          stall
);

    tq_pkg::tq_state_e [tq_pkg::NUM_TQ_ENTRY-1:0] next_state;
    logic [tq_pkg::NUM_TQ_ENTRY-1:0]               idle;

    always_comb begin
        for (int i = 0; i < tq_pkg::NUM_TQ_ENTRY; i++) begin
            idle[i]       = (state[i] == tq_pkg::S_IDLE);
            fill_ready[i] = (state[i] == tq_pkg::S_MB_FILL_READY);
        end
    end

    assign stall    = ~|idle;  // every entry busy
    assign alloc_id = tq_pkg::first_set(idle);

    // a request merging into an entry needs no new one
    always_comb begin
        for (int i = 0; i < tq_pkg::NUM_TQ_ENTRY; i++) begin
            alloc[i] = core_req.valid && !any_mb_hit && idle[i] &&
                       (alloc_id == tq_pkg::tq_id_t'(i));
        end
    end

    // ----------------------------------------
    // next state
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < tq_pkg::NUM_TQ_ENTRY; i++) begin
            next_state[i] = state[i];
            case (state[i])
                tq_pkg::S_IDLE: begin
                    if (alloc[i]) next_state[i] = tq_pkg::S_LU_CORE;
                end
                tq_pkg::S_LU_CORE: begin
                    if (lu_rsp.valid && lu_rsp.tq_id == tq_pkg::tq_id_t'(i)) begin
                        if (lu_rsp.lu_result == tq_pkg::HIT)
                            next_state[i] = tq_pkg::S_IDLE;
                        else if (lu_rsp.lu_result == tq_pkg::MISS)
                            next_state[i] = tq_pkg::S_MB_WAIT_FILL;
                    end
                end
                tq_pkg::S_MB_WAIT_FILL: begin
                    if (fm_rsp.valid && fm_rsp.tq_id == tq_pkg::tq_id_t'(i))
                        next_state[i] = tq_pkg::S_MB_FILL_READY;
                end
                default: begin  // fill ready
                    if (fill_grant && fill_id == tq_pkg::tq_id_t'(i))
                        next_state[i] = tq_pkg::S_IDLE;  // echo carries the rest
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < tq_pkg::NUM_TQ_ENTRY; i++) begin
            if (!rst_n) state[i] <= tq_pkg::S_IDLE;
            else        state[i] <= next_state[i];
        end
    end

endmodule

/* tq_fill_arbiter.sv */
// round-robin choice of the next fill lookup
// grants only in cycles without a core request
`timescale 1ns/1ps

module tq_fill_arbiter (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [tq_pkg::NUM_TQ_ENTRY-1:0] fill_ready,
    input  logic                            core_valid,
    output logic                            fill_grant,
    output tq_pkg::tq_id_t                  fill_id
);

    tq_pkg::tq_id_t ptr;   // first entry to look at
    tq_pkg::tq_id_t cand;
    logic           found;

    // first ready entry at or after the pointer
    always_comb begin
        found   = 1'b0;
        fill_id = ptr;
        cand    = ptr;
        for (int k = 0; k < tq_pkg::NUM_TQ_ENTRY; k++) begin
            cand = ptr + tq_pkg::tq_id_t'(k);  // wraps
            if (!found && fill_ready[cand]) begin
                found   = 1'b1;
                fill_id = cand;
            end
        end
    end

    assign fill_grant = found && !core_valid;

    always_ff @(posedge clk) begin
        if (!rst_n)
            ptr <= '0;
        else if (fill_grant)
            ptr <= fill_id + tq_pkg::tq_id_t'(1);
    end

endmodule

/* tq_merge_buffer.sv */
// per-entry line storage of the transaction queue
// holds address, read mark and the merged line, and detects same-line hits
`timescale 1ns/1ps

module tq_merge_buffer (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  tq_pkg::core_req_t                             core_req,
    input  tq_pkg::tq_state_e [tq_pkg::NUM_TQ_ENTRY-1:0] state,
    input  logic [tq_pkg::NUM_TQ_ENTRY-1:0]               alloc,
    input  tq_pkg::fm_rsp_t                               fm_rsp,
    input  tq_pkg::tq_id_t                                fill_id,
    output logic [tq_pkg::NUM_TQ_ENTRY-1:0]               rd_hit,
    output logic [tq_pkg::NUM_TQ_ENTRY-1:0]               wr_hit,
    output logic                                          any_mb_hit,
    output tq_pkg::tq_id_t                                wr_hit_id,
    output tq_pkg::fill_entry_t                           fill_entry
);

    localparam int N = tq_pkg::NUM_TQ_ENTRY;

    tq_pkg::line_addr_t                                  line_addr [N];
    tq_pkg::word_offset_t                                word_off  [N];
    logic [tq_pkg::REG_ID_W-1:0]                         reg_id    [N];
    tq_pkg::line_t                                       line      [N];
    logic [N-1:0]                                        rd_ind;
    logic [N-1:0][tq_pkg::WORDS_PER_LINE-1:0]            modified;  // words written by the core

    tq_pkg::line_addr_t                  req_line;
    tq_pkg::word_offset_t                req_off;
    logic                                req_wr;
    logic [tq_pkg::WORDS_PER_LINE-1:0]   word_sel;
    logic [N-1:0]                        fm_fill;

    assign req_line = core_req.address[tq_pkg::MSB_TAG:tq_pkg::LSB_SET];
    assign req_off  = core_req.address[tq_pkg::MSB_WORD_OFFSET:tq_pkg::LSB_WORD_OFFSET];
    assign req_wr   = (core_req.opcode == tq_pkg::WR_OP);

    always_comb begin
        word_sel          = '0;
        word_sel[req_off] = 1'b1;
    end

    // ----------------------------------------
    // same-line hit detection
    // ----------------------------------------
    always_comb begin
        for (int i = 0; i < N; i++) begin
            rd_hit[i] = core_req.valid && !req_wr && (req_line == line_addr[i]) &&
                        !rd_ind[i] &&
                        (state[i] == tq_pkg::S_MB_WAIT_FILL ||
                         state[i] == tq_pkg::S_MB_FILL_READY);
            wr_hit[i] = core_req.valid && req_wr && (req_line == line_addr[i]) &&
                        (state[i] != tq_pkg::S_IDLE);
            fm_fill[i] = fm_rsp.valid && (fm_rsp.tq_id == tq_pkg::tq_id_t'(i)) &&
                         (state[i] == tq_pkg::S_MB_WAIT_FILL);
        end
    end

    assign any_mb_hit = |{rd_hit, wr_hit};
    assign wr_hit_id  = tq_pkg::first_set(wr_hit);

    // ----------------------------------------
    // read mark and modified mask
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ind   <= '0;
            modified <= '0;
        end else begin
            for (int i = 0; i < N; i++) begin
                if (alloc[i]) begin
                    rd_ind[i]   <= !req_wr;
                    modified[i] <= req_wr ? word_sel : '0;
                end
                if (rd_hit[i]) rd_ind[i] <= 1'b1;  // answered by this fill
                if (wr_hit[i]) modified[i] <= modified[i] | word_sel;
            end
        end
    end

    // address fields and line data
    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            if (alloc[i]) line_addr[i] <= req_line;
            if (alloc[i] || rd_hit[i]) begin
                word_off[i] <= req_off;
                reg_id[i]   <= core_req.reg_id;
            end
            if (fm_fill[i]) begin
                for (int w = 0; w < tq_pkg::WORDS_PER_LINE; w++) begin
                    if (!modified[i][w]) line[i][w] <= fm_rsp.line[w];
                end
            end
            // core word last, so it wins over a fill in the same cycle
            if ((alloc[i] && req_wr) || wr_hit[i]) line[i][req_off] <= core_req.data;
        end
    end

    assign fill_entry.line_addr     = line_addr[fill_id];
    assign fill_entry.word_offset   = word_off[fill_id];
    assign fill_entry.reg_id        = reg_id[fill_id];
    assign fill_entry.rd_indication = rd_ind[fill_id];
    assign fill_entry.line          = line[fill_id];

endmodule

/* tq_pipe_port.sv */
// lookup request mux and core response path
// core requests go first, a granted fill takes any idle slot
`timescale 1ns/1ps

module tq_pipe_port (
    input  tq_pkg::core_req_t               core_req,
    input  tq_pkg::tq_id_t                  alloc_id,
    input  tq_pkg::tq_id_t                  wr_hit_id,
    input  logic [tq_pkg::NUM_TQ_ENTRY-1:0] rd_hit,
    input  logic [tq_pkg::NUM_TQ_ENTRY-1:0] wr_hit,
    input  logic                            fill_grant,
    input  tq_pkg::tq_id_t                  fill_id,
    input  tq_pkg::fill_entry_t             fill_entry,
    output tq_pkg::lu_req_t                 lu_req,
    input  tq_pkg::lu_rsp_t                 lu_rsp,
    output tq_pkg::core_rsp_t               core_rsp
);

    tq_pkg::word_offset_t rsp_off;
    logic                 rd_hit_rsp;
    logic                 fill_rd_rsp;

    // ----------------------------------------
    // lookup request
    // ----------------------------------------
    always_comb begin
        lu_req = '0;
        if (core_req.valid) begin
            lu_req.valid         = 1'b1;
            lu_req.lu_op         = (core_req.opcode == tq_pkg::WR_OP) ? tq_pkg::WR_LU
                                                                      : tq_pkg::RD_LU;
            lu_req.address       = core_req.address;
            lu_req.tq_id         = (|wr_hit) ? wr_hit_id : alloc_id;
            lu_req.reg_id        = core_req.reg_id;
            lu_req.rd_indication = (core_req.opcode == tq_pkg::RD_OP);
            lu_req.mb_hit_cancel = (|rd_hit) || (|wr_hit);  // merged into an entry
            if (core_req.opcode == tq_pkg::WR_OP)
                lu_req.payload.wr.word = core_req.data;
        end else if (fill_grant) begin
            lu_req.valid         = 1'b1;
            lu_req.lu_op         = tq_pkg::FILL_LU;
            lu_req.address       = {fill_entry.line_addr, fill_entry.word_offset,
                                    {tq_pkg::LSB_WORD_OFFSET{1'b0}}};
            lu_req.tq_id         = fill_id;
            lu_req.reg_id        = fill_entry.reg_id;
            lu_req.rd_indication = fill_entry.rd_indication;
            lu_req.payload.line  = fill_entry.line;
        end
    end

    // ----------------------------------------
    // core response, all from the echo
    // ----------------------------------------
    assign rsp_off     = lu_rsp.address[tq_pkg::MSB_WORD_OFFSET:tq_pkg::LSB_WORD_OFFSET];
    assign rd_hit_rsp  = (lu_rsp.lu_op == tq_pkg::RD_LU) && (lu_rsp.lu_result == tq_pkg::HIT);
    assign fill_rd_rsp = (lu_rsp.lu_op == tq_pkg::FILL_LU) && lu_rsp.rd_indication;

    assign core_rsp.valid   = lu_rsp.valid && (rd_hit_rsp || fill_rd_rsp);
    assign core_rsp.address = lu_rsp.address;
    assign core_rsp.reg_id  = lu_rsp.reg_id;
    assign core_rsp.data    = lu_rsp.line[rsp_off];  // requested word

endmodule

/* tq_pkg.sv */
// shared sizes, address fields and port types of the cache transaction queue
// compile this first, the other files refer to it as tq_pkg::name
package tq_pkg;

    // ----------------------------------------
    // sizes and address fields
    // ----------------------------------------
    localparam int NUM_TQ_ENTRY    = 4;
    localparam int WORD_W          = 32;
    localparam int WORDS_PER_LINE  = 4;
    localparam int LINE_W          = WORD_W * WORDS_PER_LINE;
    localparam int ADDR_W          = 20;
    localparam int LSB_WORD_OFFSET = 2;  // byte offset below
    localparam int MSB_WORD_OFFSET = 3;
    localparam int LSB_SET         = 4;
    localparam int MSB_TAG         = 19;
    localparam int REG_ID_W        = 5;

    typedef logic [MSB_TAG-LSB_SET:0]                 line_addr_t;
    typedef logic [MSB_WORD_OFFSET-LSB_WORD_OFFSET:0] word_offset_t;
    typedef logic [$clog2(NUM_TQ_ENTRY)-1:0]          tq_id_t;
    typedef logic [WORDS_PER_LINE-1:0][WORD_W-1:0]    line_t;  // word 0 in the low bits

    typedef enum logic       {RD_OP, WR_OP}                 opcode_e;
    typedef enum logic [1:0] {NO_LU, RD_LU, WR_LU, FILL_LU} lu_op_e;
    typedef enum logic [1:0] {HIT, MISS, FILL}              lu_result_e;
    typedef enum logic [1:0] {
        S_IDLE,
        S_LU_CORE,        // waiting for the core lookup result
        S_MB_WAIT_FILL,   // missed, waiting for far memory
        S_MB_FILL_READY   // line complete, waiting for a fill slot
    } tq_state_e;

    // ----------------------------------------
    // port structs
    // ----------------------------------------
    typedef struct packed {
        logic                valid;
        opcode_e             opcode;
        logic [ADDR_W-1:0]   address;
        logic [REG_ID_W-1:0] reg_id;
        logic [WORD_W-1:0]   data;
    } core_req_t;

    typedef struct packed {
        logic                valid;
        logic [ADDR_W-1:0]   address;
        logic [REG_ID_W-1:0] reg_id;
        logic [WORD_W-1:0]   data;
    } core_rsp_t;

    typedef struct packed {
        logic   valid;
        tq_id_t tq_id;
        line_t  line;
    } fm_rsp_t;

    // lookup payload, a full line for FILL_LU or one word for WR_LU
    typedef union packed {
        line_t line;
        struct packed {
            logic [LINE_W-WORD_W-1:0] zero;
            logic [WORD_W-1:0]        word;
        } wr;
    } lu_payload_u;

    typedef struct packed {
        logic                valid;
        lu_op_e              lu_op;
        logic [ADDR_W-1:0]   address;
        tq_id_t              tq_id;
        logic [REG_ID_W-1:0] reg_id;
        logic                rd_indication;
        logic                mb_hit_cancel;  // pipe drops it, no response
        lu_payload_u         payload;
    } lu_req_t;

    typedef struct packed {
        logic                valid;
        lu_op_e              lu_op;
        lu_result_e          lu_result;
        logic [ADDR_W-1:0]   address;
        tq_id_t              tq_id;
        logic [REG_ID_W-1:0] reg_id;
        logic                rd_indication;
        line_t               line;
    } lu_rsp_t;

    // granted entry as seen by the pipe port
    typedef struct packed {
        line_addr_t          line_addr;
        word_offset_t        word_offset;
        logic [REG_ID_W-1:0] reg_id;
        logic                rd_indication;
        line_t               line;
    } fill_entry_t;

    // index of the lowest set bit, 0 when none is set
    function automatic tq_id_t first_set(input logic [NUM_TQ_ENTRY-1:0] vec);
        tq_id_t idx;
        idx = '0;
        for (int i = NUM_TQ_ENTRY - 1; i >= 0; i--) begin
            if (vec[i]) idx = tq_id_t'(i);
        end
        return idx;
    endfunction

endpackage

/* verilog.f */
tq_pkg.sv
tq_entry_fsm.sv
tq_merge_buffer.sv
tq_fill_arbiter.sv
tq_pipe_port.sv
cache_tq.sv
tb_cache_tq.sv
